// ==== filelist.f ====
source/mem_bus_pkg.sv
source/unaligned_pkg.sv
source/request_latch.sv
source/access_sequencer.sv
source/read_aligner.sv
source/word_memory.sv
source/unaligned_access_top.sv
testbench/unaligned_access_tb.sv

// ==== source/access_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module access_sequencer (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              start,
    input  wire                              saved_write,
    input  wire unaligned_pkg::byte_addr_t   saved_addr,
    input  wire [mem_bus_pkg::DATA_W-1:0]    saved_wdata,
    input  wire [mem_bus_pkg::DATA_W-1:0]    saved_wmask,
    input  wire                              mem_ready,
    input  wire                              mem_rvalid,
    input  wire [mem_bus_pkg::DATA_W-1:0]    mem_rdata,
    output logic                             mem_valid,
    output logic                             mem_write,
    output logic [mem_bus_pkg::ADDR_W-1:0]   mem_addr,
    output logic [mem_bus_pkg::DATA_W-1:0]   mem_wdata,
    output logic [mem_bus_pkg::DATA_W-1:0]   first_word,
    output logic                             read_last,
    output logic                             done
);

    localparam int DW = mem_bus_pkg::DATA_W;

    unaligned_pkg::seq_state_t state;

    logic [DW-1:0]   second_word;
    logic            aligned;
    logic            plain_write;
    logic            second_half;
    logic            accept;
    logic [4:0]      byte_shift;
    logic [2*DW-1:0] new_pair;
    logic [2*DW-1:0] mask_pair;
    logic [2*DW-1:0] merged_pair;

    assign aligned     = saved_addr.part.offset == 2'd0;
    assign plain_write = saved_write && aligned && saved_wmask == mem_bus_pkg::FULL_MASK;
    assign accept      = mem_valid && mem_ready;

    // States that work on the word after the first one
    assign second_half = state inside {unaligned_pkg::ST_CMD2, unaligned_pkg::ST_RWAIT2,
                                       unaligned_pkg::ST_WR2};

    // New bytes placed at the byte offset over the fetched word pair
    assign byte_shift  = {saved_addr.part.offset, 3'b000};
    assign new_pair    = {{DW{1'b0}}, saved_wdata} << byte_shift;
    assign mask_pair   = {{DW{1'b0}}, saved_wmask} << byte_shift;
    assign merged_pair = ({second_word, first_word} & ~mask_pair) | (new_pair & mask_pair);

    always_comb begin
        mem_valid = state inside {unaligned_pkg::ST_CMD1, unaligned_pkg::ST_CMD2,
                                  unaligned_pkg::ST_WR1, unaligned_pkg::ST_WR2};
        mem_write = (state == unaligned_pkg::ST_CMD1 && plain_write)
                  || state == unaligned_pkg::ST_WR1 || state == unaligned_pkg::ST_WR2;
        mem_addr  = {saved_addr.part.word_idx + (second_half ? 1'b1 : 1'b0), 2'b00};
        case (state)
            unaligned_pkg::ST_CMD1: mem_wdata = saved_wdata;
            unaligned_pkg::ST_WR1:  mem_wdata = merged_pair[DW-1:0];
            unaligned_pkg::ST_WR2:  mem_wdata = merged_pair[2*DW-1:DW];
            default:                mem_wdata = '0;
        endcase
    end

    // Final data beat of a read request
    assign read_last = mem_rvalid && !saved_write
                     && ((state == unaligned_pkg::ST_RWAIT1 && aligned)
                         || state == unaligned_pkg::ST_RWAIT2);

    assign done = state == unaligned_pkg::ST_FINISH;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= unaligned_pkg::ST_IDLE;
        end else begin
            case (state)
                unaligned_pkg::ST_IDLE: begin
                    if (start) begin
                        state <= unaligned_pkg::ST_CMD1;
                    end
                end
                unaligned_pkg::ST_CMD1: begin
                    if (accept) begin
                        state <= plain_write ? unaligned_pkg::ST_FINISH
                                             : unaligned_pkg::ST_RWAIT1;
                    end
                end
                unaligned_pkg::ST_RWAIT1: begin
                    if (mem_rvalid) begin
                        if (!aligned) begin
                            state <= unaligned_pkg::ST_CMD2;
                        end else if (saved_write) begin
                            state <= unaligned_pkg::ST_WR1;
                        end else begin
                            state <= unaligned_pkg::ST_FINISH;
                        end
                    end
                end
                unaligned_pkg::ST_CMD2: begin
                    if (accept) begin
                        state <= unaligned_pkg::ST_RWAIT2;
                    end
                end
                unaligned_pkg::ST_RWAIT2: begin
                    if (mem_rvalid) begin
                        state <= saved_write ? unaligned_pkg::ST_WR1
                                             : unaligned_pkg::ST_FINISH;
                    end
                end
                unaligned_pkg::ST_WR1: begin
                    if (accept) begin
                        state <= aligned ? unaligned_pkg::ST_FINISH
                                         : unaligned_pkg::ST_WR2;
                    end
                end
                unaligned_pkg::ST_WR2: begin
                    if (accept) begin
                        state <= unaligned_pkg::ST_FINISH;
                    end
                end
                default: begin
                    state <= unaligned_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Fetched words kept for merging and for the aligner
    always_ff @(posedge clk) begin
        if (state == unaligned_pkg::ST_RWAIT1 && mem_rvalid) begin
            first_word <= mem_rdata;
        end
        if (state == unaligned_pkg::ST_RWAIT2 && mem_rvalid) begin
            second_word <= mem_rdata;
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write)
                                    && $stable(mem_addr) && $stable(mem_wdata)
    );

endmodule

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // Data word and write mask share one width
    localparam int DATA_W = 32;

    // Byte address seen by the load/store unit
    localparam int ADDR_W = 32;

    // Depth of the word memory, addresses wrap at this size
    localparam int MEM_WORDS = 64;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Only this mask lets an aligned write skip the read-modify-write
    localparam logic [DATA_W-1:0] FULL_MASK = {DATA_W{1'b1}};

endpackage

`default_nettype wire

// ==== source/read_aligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_aligner (
    input  wire unaligned_pkg::byte_addr_t   saved_addr,
    input  wire [mem_bus_pkg::DATA_W-1:0]    first_word,
    input  wire [mem_bus_pkg::DATA_W-1:0]    mem_rdata,
    input  wire                              read_last,
    output logic                             resp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0]   resp_rdata
);

    // Response is valid only on the last read beat
    assign resp_valid = read_last;

    // Upper bytes of the first word form the low part of the result,
    // low bytes of the second word fill the top
    always_comb begin
        case (saved_addr.part.offset)
            2'd1:    resp_rdata = {mem_rdata[7:0], first_word[31:8]};
            2'd2:    resp_rdata = {mem_rdata[15:0], first_word[31:16]};
            2'd3:    resp_rdata = {mem_rdata[23:0], first_word[31:24]};
            default: resp_rdata = mem_rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/request_latch.sv ====
`timescale 1ns/10ps
`default_nettype none

module request_latch (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              req_valid,
    input  wire                              req_write,
    input  wire [mem_bus_pkg::ADDR_W-1:0]    req_addr,
    input  wire [mem_bus_pkg::DATA_W-1:0]    req_wdata,
    input  wire [mem_bus_pkg::DATA_W-1:0]    req_wmask,
    input  wire                              done,
    output logic                             req_ready,
    output logic                             start,
    output logic                             saved_write,
    output unaligned_pkg::byte_addr_t        saved_addr,
    output logic [mem_bus_pkg::DATA_W-1:0]   saved_wdata,
    output logic [mem_bus_pkg::DATA_W-1:0]   saved_wmask
);

    logic busy;
    logic accept;

    assign req_ready = !busy;
    assign accept    = req_valid && !busy;

    // Busy from the cycle after acceptance until the cycle after done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Request fields stay put while the access runs
    always_ff @(posedge clk) begin
        if (accept) begin
            saved_write     <= req_write;
            saved_addr.raw  <= req_addr;
            saved_wdata     <= req_wdata;
            saved_wmask     <= req_wmask;
        end
    end

    a_done_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> busy
    );

endmodule

`default_nettype wire

// ==== source/unaligned_access_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module unaligned_access_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              req_valid,
    input  wire                              req_write,
    input  wire [mem_bus_pkg::ADDR_W-1:0]    req_addr,
    input  wire [mem_bus_pkg::DATA_W-1:0]    req_wdata,
    input  wire [mem_bus_pkg::DATA_W-1:0]    req_wmask,
    output logic                             req_ready,
    output logic                             resp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0]   resp_rdata
);

    // Latch to sequencer
    logic                            start;
    logic                            done;
    logic                            saved_write;
    unaligned_pkg::byte_addr_t       saved_addr;
    logic [mem_bus_pkg::DATA_W-1:0]  saved_wdata;
    logic [mem_bus_pkg::DATA_W-1:0]  saved_wmask;

    // Sequencer to memory
    logic                            mem_valid;
    logic                            mem_write;
    logic [mem_bus_pkg::ADDR_W-1:0]  mem_addr;
    logic [mem_bus_pkg::DATA_W-1:0]  mem_wdata;
    logic                            mem_ready;
    logic                            mem_rvalid;
    logic [mem_bus_pkg::DATA_W-1:0]  mem_rdata;

    // Sequencer to aligner
    logic [mem_bus_pkg::DATA_W-1:0]  first_word;
    logic                            read_last;

    request_latch i_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wmask   (req_wmask),
        .done        (done),
        .req_ready   (req_ready),
        .start       (start),
        .saved_write (saved_write),
        .saved_addr  (saved_addr),
        .saved_wdata (saved_wdata),
        .saved_wmask (saved_wmask)
    );

    access_sequencer i_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .saved_write (saved_write),
        .saved_addr  (saved_addr),
        .saved_wdata (saved_wdata),
        .saved_wmask (saved_wmask),
        .mem_ready   (mem_ready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .first_word  (first_word),
        .read_last   (read_last),
        .done        (done)
    );

    read_aligner i_aligner (
        .saved_addr  (saved_addr),
        .first_word  (first_word),
        .mem_rdata   (mem_rdata),
        .read_last   (read_last),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata)
    );

    word_memory i_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== source/unaligned_pkg.sv ====
`default_nettype none

package unaligned_pkg;

    // Access sequencer states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CMD1,
        ST_RWAIT1,
        ST_CMD2,
        ST_RWAIT2,
        ST_WR1,
        ST_WR2,
        ST_FINISH
    } seq_state_t;

    // Word index and byte offset within the word
    typedef struct packed {
        logic [mem_bus_pkg::ADDR_W-3:0] word_idx;
        logic [1:0]                     offset;
    } addr_fields_t;

    // Same address word, either as a plain byte address or split
    typedef union packed {
        logic [mem_bus_pkg::ADDR_W-1:0] raw;
        addr_fields_t                   part;
    } byte_addr_t;

endpackage

`default_nettype wire

// ==== source/word_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_memory (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              mem_valid,
    input  wire                              mem_write,
    input  wire [mem_bus_pkg::ADDR_W-1:0]    mem_addr,
    input  wire [mem_bus_pkg::DATA_W-1:0]    mem_wdata,
    output logic                             mem_ready,
    output logic                             mem_rvalid,
    output logic [mem_bus_pkg::DATA_W-1:0]   mem_rdata
);

    logic [mem_bus_pkg::DATA_W-1:0]    mem [mem_bus_pkg::MEM_WORDS];
    logic [mem_bus_pkg::MEM_IDX_W-1:0] idx;
    logic                              busy;
    logic                              accept;

    // Word index taken modulo the memory size
    assign idx       = mem_addr[mem_bus_pkg::MEM_IDX_W+1:2];
    assign mem_ready = !busy;
    assign accept    = mem_valid && mem_ready;

    initial begin
        for (int i = 0; i < mem_bus_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // One busy cycle after every command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            mem_rvalid <= 1'b0;
        end else begin
            busy       <= accept;
            mem_rvalid <= accept && !mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem_write) begin
            mem[idx] <= mem_wdata;
        end
        if (accept && !mem_write) begin
            mem_rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// ==== testbench/unaligned_access_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module unaligned_access_tb;

    localparam int DW = mem_bus_pkg::DATA_W;
    localparam int MEM_BYTES = mem_bus_pkg::MEM_WORDS * 4;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLES_PER_TEST = 40;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          req_valid;
    logic          req_write;
    logic [31:0]   req_addr;
    logic [DW-1:0] req_wdata;
    logic [DW-1:0] req_wmask;
    logic          req_ready;
    logic          resp_valid;
    logic [DW-1:0] resp_rdata;

    // Tests as read from the data file
    logic [7:0]    test_op[$];
    logic [31:0]   test_addr[$];
    logic [DW-1:0] test_wdata[$];
    logic [DW-1:0] test_wmask[$];
    logic [DW-1:0] test_rdata[$];
    logic          tests_loaded = 1'b0;

    // Byte-wide view of the memory contents
    logic [7:0]    shadow [MEM_BYTES];

    unaligned_access_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH at time %0t: %s (got %h, expected %h)",
                                     $time, what, actual, expected));
        end
    endtask

    // Little-endian word starting at any byte address
    function automatic logic [DW-1:0] expected_read(input logic [31:0] addr);
        logic [DW-1:0] value;
        int            idx;
        value = '0;
        for (int b = 0; b < 4; b++) begin
            idx = (addr + b) % MEM_BYTES;
            value[8*b +: 8] = shadow[idx];
        end
        return value;
    endfunction

    // Bit i of the mask guards bit i of the value
    task automatic apply_write(input logic [31:0] addr, input logic [DW-1:0] wdata,
                               input logic [DW-1:0] wmask);
        int         idx;
        logic [7:0] m;
        for (int b = 0; b < 4; b++) begin
            idx = (addr + b) % MEM_BYTES;
            m = wmask[8*b +: 8];
            shadow[idx] = (shadow[idx] & ~m) | (wdata[8*b +: 8] & m);
        end
    endtask

    task automatic load_tests();
        int            fd;
        int            r;
        int            ch;
        logic [7:0]    op;
        logic [31:0]   addr;
        logic [DW-1:0] wdata;
        logic [DW-1:0] wmask;
        logic [DW-1:0] rdata;
        fd = $fopen("testbench/unaligned_tests.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open testbench/unaligned_tests.txt");
        end
        r = $fscanf(fd, " %c", op);
        while (r == 1) begin
            if (op == "#") begin
                // Comment line, drop the rest of it
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (op != "R" && op != "W") begin
                report_failure($sformatf("Unknown operation '%c' in the test file", op));
            end else begin
                r = $fscanf(fd, "%h %h %h %h", addr, wdata, wmask, rdata);
                if (r != 4) begin
                    report_failure("Test file line has fewer than five fields");
                end
                test_op.push_back(op);
                test_addr.push_back(addr);
                test_wdata.push_back(wdata);
                test_wmask.push_back(wmask);
                test_rdata.push_back(rdata);
            end
            r = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
    endtask

    // One request from acceptance to completion, entered and left on a falling edge
    task automatic run_request(input int n);
        int            resp_count;
        logic          is_read;
        logic [DW-1:0] model_rdata;
        is_read = test_op[n] == "R";
        resp_count = 0;
        model_rdata = expected_read(test_addr[n]);
        if (is_read) begin
            check_value(test_rdata[n], model_rdata,
                        $sformatf("test %0d file value against byte model", n));
        end else begin
            apply_write(test_addr[n], test_wdata[n], test_wmask[n]);
        end
        while (!req_ready) begin
            @(negedge clk);
        end
        req_valid = 1'b1;
        req_write = !is_read;
        req_addr  = test_addr[n];
        req_wdata = test_wdata[n];
        req_wmask = test_wmask[n];
        @(negedge clk);
        req_valid = 1'b0;
        check_value(req_ready, 1'b0, $sformatf("test %0d req_ready after acceptance", n));
        while (!req_ready) begin
            if (resp_valid) begin
                resp_count++;
                check_value(resp_rdata, model_rdata,
                            $sformatf("test %0d read data at %h", n, test_addr[n]));
            end
            @(negedge clk);
        end
        check_value(resp_count, is_read ? 1 : 0,
                    $sformatf("test %0d number of resp_valid pulses", n));
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        load_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value(req_ready, 1'b1, "req_ready after reset");
        check_value(resp_valid, 1'b0, "resp_valid after reset");
        for (int i = 0; i < test_op.size(); i++) begin
            run_request(i);
        end
        $display("Everything OK");
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        int limit;
        wait (tests_loaded);
        limit = test_op.size() * CYCLES_PER_TEST + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        report_failure($sformatf("Run hung, tests not finished after %0d cycles", limit));
    end

endmodule

`default_nettype wire

// ==== testbench/unaligned_tests.txt ====
# op addr wdata wmask expected_rdata, all fields in hex
# op is R or W; expected_rdata is ignored for writes
# aligned full writes and reads
W 00000000 cafebebe ffffffff 00000000
W 00000004 deadbeef ffffffff 00000000
R 00000000 00000000 00000000 cafebebe
R 00000004 00000000 00000000 deadbeef
# unaligned reads across the pair
R 00000001 00000000 00000000 efcafebe
R 00000002 00000000 00000000 beefcafe
R 00000003 00000000 00000000 adbeefca
# aligned partial writes
W 00000008 11223344 ffffffff 00000000
W 00000008 aabbccdd 0000ff00 00000000
R 00000008 00000000 00000000 1122cc44
W 00000008 5a5a5a5a f0f0000f 00000000
R 00000008 00000000 00000000 5152cc4a
# unaligned writes at offsets 1 to 3
W 00000010 01234567 ffffffff 00000000
W 00000014 89abcdef ffffffff 00000000
W 00000011 a1b2c3d4 ffffffff 00000000
R 00000010 00000000 00000000 b2c3d467
R 00000014 00000000 00000000 89abcda1
W 00000016 ffffffff 00ffff00 00000000
R 00000014 00000000 00000000 ffabcda1
R 00000018 00000000 00000000 000000ff
W 00000013 76543210 0ff0f00f 00000000
R 00000010 00000000 00000000 b0c3d467
R 00000014 00000000 00000000 ffa65d31
R 00000018 00000000 00000000 000000ff
R 00000013 00000000 00000000 a65d31b0
W 00000022 cafef00d ffffffff 00000000
R 00000020 00000000 00000000 f00d0000
R 00000024 00000000 00000000 0000cafe
R 00000022 00000000 00000000 cafef00d
# access that wraps past the last word
W 000000fd 12345678 ffffffff 00000000
R 000000fc 00000000 00000000 34567800
R 00000000 00000000 00000000 cafebe12
R 000000fd 00000000 00000000 12345678
